// ==== hdl/l1d_cache.sv ====
`timescale 1ns/1ns
`include "lsu_settings.svh"

module l1d_cache
  import lsu_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n_i,
  l1d_if.cache  cache
);

  word_t                 data_mem [`L1D_LINES];
  logic [`L1D_TAG_W-1:0] tag_mem  [`L1D_LINES];
  logic [`L1D_LINES-1:0] valid_q;
  logic [`L1D_IDX_W-1:0] idx;
  logic                  tag_match;

  assign idx       = cache.lookup_idx;
  assign tag_match = (tag_mem[idx] == cache.lookup_tag);

  // hit straight from the arrays, same cycle as the lookup
  assign cache.hit      = valid_q[idx] && tag_match;
  assign cache.hit_data = data_mem[idx];

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      valid_q <= '0;
    else if (cache.fill_en)
      valid_q[idx] <= 1'b1;
    else if (cache.inval_en)
      valid_q[idx] <= 1'b0;
  end

  // write-invalidate, so only a miss fill writes a line
  always_ff @(posedge clk)
  begin
    if (cache.fill_en)
    begin
      data_mem[idx] <= cache.fill_data;
      tag_mem[idx]  <= cache.lookup_tag;
    end
  end

endmodule

// ==== hdl/l1d_if.sv ====
`timescale 1ns/1ns
`include "lsu_settings.svh"

interface l1d_if
  import lsu_pkg::*;
();

  addr_t                 lookup_addr;
  logic                  fill_en;
  word_t                 fill_data;
  logic                  inval_en;
  logic                  hit;
  word_t                 hit_data;
  logic [`L1D_IDX_W-1:0] lookup_idx;
  logic [`L1D_TAG_W-1:0] lookup_tag;

  // fill and invalidate share the lookup address
  assign lookup_idx = lookup_addr[`L1D_IDX_W+1:2];
  assign lookup_tag = lookup_addr[31:`L1D_IDX_W+2];

  modport ctrl (
    output lookup_addr,
    output fill_en,
    output fill_data,
    output inval_en,
    input  hit,
    input  hit_data
  );

  modport cache (
    input  lookup_idx,
    input  lookup_tag,
    input  fill_en,
    input  fill_data,
    input  inval_en,
    output hit,
    output hit_data
  );

endinterface

// ==== hdl/lsu_ctrl.sv ====
`timescale 1ns/1ns

module lsu_ctrl
  import lsu_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n_i,
  input  logic    req_valid_i,
  output logic    req_ready_o,
  input  lsu_op_e req_op_i,
  input  addr_t   req_addr_i,
  input  word_t   req_wdata_i,
  output logic    rsp_valid_o,
  output word_t   rsp_rdata_o,
  wb_if.master    bus,
  l1d_if.ctrl     cache
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  lsu_op_e     op_q;
  addr_t       addr_q;
  word_t       wdata_q;
  logic        accept;
  logic        is_store;
  logic        load_hit;
  sel_t        store_sel;
  word_t       store_data;

  // align the addressed lane down to bit 0, then extend
  function automatic word_t load_extend(lsu_op_e op, word_t word, logic [1:0] ofs);
    word_t s;
    s = word >> {ofs, 3'b000};
    case (op)
      LB:      return {{24{s[7]}}, s[7:0]};
      LBU:     return {24'h0, s[7:0]};
      LH:      return {{16{s[15]}}, s[15:0]};
      LHU:     return {16'h0, s[15:0]};
      default: return s;
    endcase
  endfunction

  assign accept      = req_valid_i && req_ready_o;
  assign req_ready_o = (state_q == IDLE);
  assign rsp_valid_o = (state_q == RESP);
  assign is_store    = op_q inside {SB, SH, SW};
  assign load_hit    = (state_q == LOOKUP) && !is_store && cache.hit;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (accept)
          state_d = LOOKUP;
      LOOKUP:
        if (load_hit)
          state_d = RESP;
        else
          state_d = BUS;
      BUS:
        if (bus.ack)
          state_d = RESP;
      RESP:
        state_d = IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      op_q    <= req_op_i;
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
    end
  end

  // lane select and replicated data for stores
  always_comb
  begin
    case (op_q)
      SB:
      begin
        store_sel  = sel_t'(4'b0001 << addr_q[1:0]);
        store_data = {4{wdata_q[7:0]}};
      end
      SH:
      begin
        store_sel  = sel_t'(4'b0011 << addr_q[1:0]);
        store_data = {2{wdata_q[15:0]}};
      end
      default:
      begin
        store_sel  = 4'b1111;
        store_data = wdata_q;
      end
    endcase
  end

  assign bus.cyc   = (state_q == BUS);
  assign bus.stb   = (state_q == BUS);
  assign bus.we    = is_store;
  assign bus.adr   = addr_q[31:2];
  assign bus.sel   = store_sel;
  assign bus.dat_w = store_data;

  assign cache.lookup_addr = addr_q;
  assign cache.fill_en     = (state_q == BUS) && bus.ack && !is_store;
  assign cache.fill_data   = bus.dat_r;
  // store drops the line on the edge into BUS
  assign cache.inval_en    = (state_q == LOOKUP) && is_store;

  always_ff @(posedge clk)
  begin
    if (load_hit)
      rsp_rdata_o <= load_extend(op_q, cache.hit_data, addr_q[1:0]);
    else if ((state_q == BUS) && bus.ack)
      rsp_rdata_o <= is_store ? '0 : load_extend(op_q, bus.dat_r, addr_q[1:0]);
  end

endmodule

// ==== hdl/lsu_pkg.sv ====
package lsu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // word address as seen on the data bus
  typedef logic [29:0] wadr_t;
  typedef logic [3:0]  sel_t;

  typedef enum logic [3:0] {
    LB  = 4'h0,
    LBU = 4'h1,
    LH  = 4'h2,
    LHU = 4'h3,
    LW  = 4'h4,
    SB  = 4'h8,
    SH  = 4'h9,
    SW  = 4'ha
  } lsu_op_e;

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    LOOKUP = 2'd1,
    BUS    = 2'd2,
    RESP   = 2'd3
  } ctrl_state_e;

endpackage

// ==== hdl/lsu_settings.svh ====
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// data memory depth in 32-bit words
`define LSU_MEM_WORDS 256

// direct-mapped L1D geometry
`define L1D_IDX_W 6
`define L1D_LINES (1 << `L1D_IDX_W)

// tag is addr[31:L1D_IDX_W+2]
`define L1D_TAG_W (32 - `L1D_IDX_W - 2)

`endif

// ==== hdl/lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top
  import lsu_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n_i,
  input  logic    req_valid_i,
  output logic    req_ready_o,
  input  lsu_op_e req_op_i,
  input  addr_t   req_addr_i,
  input  word_t   req_wdata_i,
  output logic    rsp_valid_o,
  output word_t   rsp_rdata_o
);

  wb_if  wb ();
  l1d_if l1d ();

  lsu_ctrl u_ctrl (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o),
    .bus         (wb.master),
    .cache       (l1d.ctrl)
  );

  l1d_cache u_cache (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .cache   (l1d.cache)
  );

  // data memory kept inside so results show at the core ports
  wb_dmem u_dmem (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .bus     (wb.slave)
  );

endmodule

// ==== hdl/wb_dmem.sv ====
`timescale 1ns/1ns
`include "lsu_settings.svh"

module wb_dmem
  import lsu_pkg::*;
(
  input  logic clk,
  input  logic rst_n_i,
  wb_if.slave  bus
);

  localparam int AW = $clog2(`LSU_MEM_WORDS);

  word_t         mem [`LSU_MEM_WORDS] = '{default: '0};
  logic [AW-1:0] idx;
  logic          access;

  // upper word-address bits are ignored
  assign idx = bus.adr[AW-1:0];

  // first cycle of a transfer only, ack marks the second
  assign access = bus.cyc && bus.stb && !bus.ack;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      bus.ack <= 1'b0;
    else
      bus.ack <= access;
  end

  always_ff @(posedge clk)
  begin
    if (access)
    begin
      if (bus.we)
      begin
        for (int b = 0; b < 4; b++)
        begin
          if (bus.sel[b])
            mem[idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
        end
      end
      else
      begin
        bus.dat_r <= mem[idx];
      end
    end
  end

endmodule

// ==== hdl/wb_if.sv ====
`timescale 1ns/1ns

interface wb_if
  import lsu_pkg::*;
();

  logic  cyc;
  logic  stb;
  logic  we;
  wadr_t adr;
  sel_t  sel;
  word_t dat_w;
  word_t dat_r;
  logic  ack;

  modport master (
    output cyc,
    output stb,
    output we,
    output adr,
    output sel,
    output dat_w,
    input  dat_r,
    input  ack
  );

  modport slave (
    input  cyc,
    input  stb,
    input  we,
    input  adr,
    input  sel,
    input  dat_w,
    output dat_r,
    output ack
  );

endinterface

// ==== project.f ====
+incdir+hdl
hdl/lsu_pkg.sv
hdl/wb_if.sv
hdl/l1d_if.sv
hdl/lsu_ctrl.sv
hdl/l1d_cache.sv
hdl/wb_dmem.sv
hdl/lsu_top.sv
tb/lsu_props.sv
tb/lsu_tb.sv

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module lsu_tb \
  -f project.f --Mdir obj_dir -o lsu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== tb/lsu_props.sv ====
`timescale 1ns/1ns

module lsu_props (
  input logic clk,
  input logic rst_n_i,
  input logic req_valid_i,
  input logic req_ready_i,
  input logic rsp_valid_i,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i
);

  logic in_flight_q;
  int   fails = 0;

  // set from acceptance until the response edge
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      in_flight_q <= 1'b0;
    else if (req_valid_i && req_ready_i)
      in_flight_q <= 1'b1;
    else if (rsp_valid_i)
      in_flight_q <= 1'b0;
  end

  ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
    ack_i |-> (cyc_i && stb_i))
    else
    begin
      fails++;
      $error("ack seen outside a bus cycle");
    end

  rsp_single: assert property (@(posedge clk) disable iff (!rst_n_i)
    rsp_valid_i |=> !rsp_valid_i)
    else
    begin
      fails++;
      $error("response valid held two cycles");
    end

  ready_low_in_flight: assert property (@(posedge clk) disable iff (!rst_n_i)
    in_flight_q |-> !req_ready_i)
    else
    begin
      fails++;
      $error("ready raised while a request is in flight");
    end

endmodule

bind lsu_top lsu_props u_props (
  .clk         (clk),
  .rst_n_i     (rst_n_i),
  .req_valid_i (req_valid_i),
  .req_ready_i (req_ready_o),
  .rsp_valid_i (rsp_valid_o),
  .cyc_i       (wb.cyc),
  .stb_i       (wb.stb),
  .ack_i       (wb.ack)
);

// ==== tb/lsu_tb.sv ====
`timescale 1ns/1ns
`include "lsu_settings.svh"

module lsu_tb
  import lsu_pkg::*;
();

  localparam int NUM_RAND = 400;
  localparam int NUM_DIR  = 4;
  localparam int NUM_REQ  = NUM_RAND + NUM_DIR;
  localparam int CLK_NS   = 100;
  localparam int IDX_W    = `L1D_IDX_W;
  localparam int MEM_AW   = $clog2(`LSU_MEM_WORDS);

  logic    clk;
  logic    rst_n_i;
  logic    req_valid_i;
  logic    req_ready_o;
  lsu_op_e req_op_i;
  addr_t   req_addr_i;
  word_t   req_wdata_i;
  logic    rsp_valid_o;
  word_t   rsp_rdata_o;

  word_t                 model_mem [`LSU_MEM_WORDS] = '{default: '0};
  logic [`L1D_LINES-1:0] shadow_valid;
  logic [`L1D_TAG_W-1:0] shadow_tag [`L1D_LINES];
  lsu_op_e               op_table [8] = '{LB, LBU, LH, LHU, LW, SB, SH, SW};
  logic [15:0]           lfsr_q;
  int                    errors;
  int                    checks;
  int                    hits_seen;
  addr_t                 last_addr;

  lsu_top lsu_top_i (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // galois lfsr stepped once per bit taken
  function automatic word_t draw_bits(int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_q[0]};
      if (lfsr_q[0])
        lfsr_q = (lfsr_q >> 1) ^ 16'hb400;
      else
        lfsr_q = lfsr_q >> 1;
    end
    return v;
  endfunction

  function automatic int size_of(lsu_op_e op);
    case (op)
      LB, LBU, SB: return 1;
      LH, LHU, SH: return 2;
      default:     return 4;
    endcase
  endfunction

  function automatic logic is_store_op(lsu_op_e op);
    return (op == SB) || (op == SH) || (op == SW);
  endfunction

  function automatic word_t model_load(lsu_op_e op, addr_t addr);
    logic [MEM_AW-1:0] w;
    int                ofs;
    logic [7:0]        b;
    logic [15:0]       h;
    w   = addr[MEM_AW+1:2];
    ofs = int'(addr[1:0]);
    b   = model_mem[w][8*ofs +: 8];
    h   = model_mem[w][8*(ofs & 2) +: 16];
    case (op)
      LB:      return word_t'(int'($signed(b)));
      LBU:     return word_t'(b);
      LH:      return word_t'(int'($signed(h)));
      LHU:     return word_t'(h);
      default: return model_mem[w];
    endcase
  endfunction

  // data byte i lands in lane ofs+i
  task automatic model_store(lsu_op_e op, addr_t addr, word_t data);
    logic [MEM_AW-1:0] w;
    int                ofs;
    w   = addr[MEM_AW+1:2];
    ofs = int'(addr[1:0]);
    for (int i = 0; i < size_of(op); i++)
      model_mem[w][8*(ofs+i) +: 8] = data[8*i +: 8];
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Fail %s expected %08h actual %08h", name, exp, act);
    end
  endtask

  task automatic check_op(string name, lsu_op_e exp, lsu_op_e act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Fail %s expected %s actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_latency(string name, int exp, int act);
    checks++;
    if (act != exp)
    begin
      errors++;
      $display("Fail %s latency expected %0d actual %0d", name, exp, act);
    end
  endtask

  // entered and left on a falling edge
  task automatic run_request(lsu_op_e op, addr_t addr, word_t wdata);
    logic [IDX_W-1:0]      idx;
    logic [`L1D_TAG_W-1:0] tag;
    logic                  store;
    logic                  exp_hit;
    word_t                 exp_data;
    int                    cycles;
    string                 name;
    idx      = addr[IDX_W+1:2];
    tag      = addr[31:IDX_W+2];
    store    = is_store_op(op);
    exp_hit  = !store && shadow_valid[idx] && (shadow_tag[idx] == tag);
    exp_data = store ? '0 : model_load(op, addr);
    name     = $sformatf("%s @%03h", op.name(), addr[9:0]);
    if (!req_ready_o)
    begin
      errors++;
      $display("unit not ready for %s", name);
    end
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    @(negedge clk);
    req_valid_i = 1'b0;
    // inputs are free once accepted
    req_addr_i  = draw_bits(32);
    req_wdata_i = draw_bits(32);
    check_op(name, op, lsu_top_i.u_ctrl.op_q);
    cycles = 1;
    while (!rsp_valid_o)
    begin
      @(negedge clk);
      cycles++;
    end
    check_word(name, exp_data, rsp_rdata_o);
    check_latency(name, exp_hit ? 1 : 3, cycles - 1);
    if (store)
    begin
      model_store(op, addr, wdata);
      shadow_valid[idx] = 1'b0;
    end
    else if (exp_hit)
      hits_seen++;
    else
    begin
      shadow_valid[idx] = 1'b1;
      shadow_tag[idx]   = tag;
    end
    @(negedge clk);
    if (rsp_valid_o)
    begin
      errors++;
      $display("response for %s lasted more than one cycle", name);
    end
  endtask

  task automatic random_request();
    word_t   r;
    lsu_op_e op;
    addr_t   addr;
    r  = draw_bits(3);
    op = op_table[r[2:0]];
    // a quarter of the requests revisit the last address
    r  = draw_bits(2);
    if (r[1:0] == 2'b00)
      addr = last_addr;
    else
    begin
      r    = draw_bits(10);
      addr = {22'h0, r[9:0]};
    end
    case (size_of(op))
      2:       addr[0] = 1'b0;
      4:       addr[1:0] = 2'b00;
      default: ;
    endcase
    last_addr = addr;
    r = draw_bits(32);
    run_request(op, addr, r);
  endtask

  initial
  begin
    clk          = 1'b0;
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = LW;
    req_addr_i   = '0;
    req_wdata_i  = '0;
    lfsr_q       = 16'd29346;
    errors       = 0;
    checks       = 0;
    hits_seen    = 0;
    last_addr    = '0;
    shadow_valid = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);
    if (!req_ready_o || rsp_valid_o)
    begin
      errors++;
      $display("wrong handshake state after reset");
    end

    // store, miss, hit, then a byte from the cached word
    run_request(SW, 32'h100, 32'ha5c3_1e77);
    run_request(LW, 32'h100, '0);
    run_request(LW, 32'h100, '0);
    run_request(LB, 32'h103, '0);

    for (int n = 0; n < NUM_RAND; n++)
      random_request();

    if (hits_seen == 0)
    begin
      errors++;
      $display("no load ever hit in the cache");
    end
    errors += lsu_top_i.u_props.fails;
    $display("checks %0d, load hits %0d, errors %0d", checks, hits_seen, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  initial
  begin
    #((NUM_REQ * 10 + 50) * CLK_NS);
    $display("watchdog expired after %0d clock periods", NUM_REQ * 10 + 50);
    $display("Testbench failed");
    $finish;
  end

endmodule
